//--- common/ifu_pkg.sv
`default_nettype none

package ifu_pkg;

  // ----------------------------------------
  // Basic words.
  // ----------------------------------------

  // Address and data word.
  typedef logic [31:0] xlen_t;

  // Word address with the byte offset stripped.
  typedef logic [29:0] word_addr_t;

  // Reads that may be in flight at once.
  localparam int OUTSTANDING_DEPTH = 2;

  // Returned words kept in the history.
  localparam int HISTORY_DEPTH = 2;

  // Words fetched ahead of next pc.
  localparam int PREFETCH_AHEAD = 2;

  // ----------------------------------------
  // Tags and buffer snapshots.
  // ----------------------------------------

  typedef struct packed {
    logic       valid;
    word_addr_t addr;
  } word_tag_t;

  typedef struct packed {
    word_tag_t tag;
    xlen_t     data;
  } buf_entry_t;

  // Tags of reads still in flight.
  typedef word_tag_t [OUTSTANDING_DEPTH-1:0] sent_snapshot_t;

  // Entry zero is the word returning this cycle.
  typedef buf_entry_t [HISTORY_DEPTH:0] valid_snapshot_t;

  // Words the current instruction still needs.
  typedef struct packed {
    logic next_word;
    logic pc_word;
  } pc_request_t;

  // True when a read for this word is in flight.
  function automatic logic tag_in_flight(word_addr_t addr, sent_snapshot_t sent);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < OUTSTANDING_DEPTH; i++) begin
      hit = hit || (sent[i].valid && sent[i].addr == addr);
    end
    return hit;
  endfunction

  // Buffered entry for this word, newest match wins.
  // A clear tag valid bit means the word is not buffered.
  function automatic buf_entry_t tag_lookup(word_addr_t addr, valid_snapshot_t snap);
    buf_entry_t hit;
    hit = '0;
    for (int i = HISTORY_DEPTH; i >= 0; i--) begin
      if (snap[i].tag.valid && snap[i].tag.addr == addr) begin
        hit = snap[i];
      end
    end
    return hit;
  endfunction

endpackage

`default_nettype wire

//--- common/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

  // ----------------------------------------
  // Memory read bus.
  // ----------------------------------------

  // Read request from the fetch unit.
  // Address is always word aligned.
  typedef struct packed {
    logic           read;
    ifu_pkg::xlen_t address;
  } mem_req_t;

  // Response side of the bus.
  // One data strobe per accepted read, in order.
  typedef struct packed {
    logic           request_ready;
    logic           read_data_valid;
    ifu_pkg::xlen_t read_data;
  } mem_rsp_t;

endpackage

`default_nettype wire

//--- ifu/ifu_prefetch.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_prefetch (
  input  wire ifu_pkg::xlen_t           pc,
  input  wire ifu_pkg::xlen_t           next_pc,
  input  wire ifu_pkg::pc_request_t     pc_request,
  input  wire ifu_pkg::sent_snapshot_t  sent_snapshot,
  input  wire ifu_pkg::valid_snapshot_t valid_snapshot,
  input  wire                           queue_full,
  output mem_bus_pkg::mem_req_t         mem_req
);

  import ifu_pkg::*;

  // Prefetch window starting at the next pc word.
  word_addr_t [PREFETCH_AHEAD-1:0] cand_addr;
  logic       [PREFETCH_AHEAD-1:0] cand_known;

  // Chosen word and whether anything is wanted at all.
  word_addr_t                      sel_addr;
  logic                            sel_found;

  // ----------------------------------------
  // Window words already held or requested.
  // ----------------------------------------
  always_comb begin : window_comb
    buf_entry_t hit;
    hit = '0;
    for (int i = 0; i < PREFETCH_AHEAD; i++) begin
      cand_addr[i]  = next_pc[31:2] + word_addr_t'(i);
      hit           = tag_lookup(cand_addr[i], valid_snapshot);
      cand_known[i] = hit.tag.valid || tag_in_flight(cand_addr[i], sent_snapshot);
    end
  end

  // ----------------------------------------
  // Read selection.
  // ----------------------------------------
  always_comb begin : select_comb
    sel_found = 1'b0;
    sel_addr  = cand_addr[0];
    // Lowest missing word of the window.
    for (int i = 0; i < PREFETCH_AHEAD; i++) begin
      if (!sel_found && !cand_known[i]) begin
        sel_found = 1'b1;
        sel_addr  = cand_addr[i];
      end
    end
    // Stalled instruction overrides prefetch.
    if (pc_request.pc_word) begin
      sel_found = 1'b1;
      sel_addr  = pc[31:2];
    end else if (pc_request.next_word) begin
      sel_found = 1'b1;
      sel_addr  = pc[31:2] + word_addr_t'(1);
    end
  end

  // No new read while the tag queue has no room.
  assign mem_req.read    = sel_found && !queue_full;
  assign mem_req.address = {sel_addr, 2'b00};

  // Issued reads never repeat a word that the buffer
  // already holds or is still waiting for.
  always_comb begin : req_check
    buf_entry_t req_hit;
    req_hit = tag_lookup(mem_req.address[31:2], valid_snapshot);
    if (mem_req.read) begin
      req_fresh_word: assert #0 (!req_hit.tag.valid &&
                                 !tag_in_flight(mem_req.address[31:2], sent_snapshot));
    end
  end

endmodule

`default_nettype wire

//--- ifu/ifu_fetch_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_fetch_buffer (
  input  wire                       clk,
  input  wire                       rest,
  input  wire                       accept,
  input  wire ifu_pkg::xlen_t       accept_addr,
  input  wire                       rsp_valid,
  input  wire ifu_pkg::xlen_t       rsp_data,
  output ifu_pkg::sent_snapshot_t   sent_snapshot,
  output ifu_pkg::valid_snapshot_t  valid_snapshot,
  output logic                      queue_full
);

  import ifu_pkg::*;

  // In-flight tag queue.
  // Oldest tag sits at index zero, valid entries are packed low.
  logic       [OUTSTANDING_DEPTH-1:0] q_valid;
  word_addr_t [OUTSTANDING_DEPTH-1:0] q_addr;
  logic       [OUTSTANDING_DEPTH-1:0] q_valid_nxt;
  word_addr_t [OUTSTANDING_DEPTH-1:0] q_addr_nxt;

  // History of returned words, newest at index zero.
  logic       [HISTORY_DEPTH-1:0]     h_valid;
  word_addr_t [HISTORY_DEPTH-1:0]     h_addr;
  xlen_t      [HISTORY_DEPTH-1:0]     h_data;

  // Low until the first cycle after reset has passed.
  logic                               buf_ready;

  // ----------------------------------------
  // Tag queue next state.
  // ----------------------------------------
  always_comb begin : queue_next_comb
    logic placed;
    placed      = 1'b0;
    q_valid_nxt = q_valid;
    q_addr_nxt  = q_addr;
    // Response retires the oldest tag.
    if (rsp_valid) begin
      for (int i = 0; i < OUTSTANDING_DEPTH - 1; i++) begin
        q_valid_nxt[i] = q_valid[i+1];
        q_addr_nxt[i]  = q_addr[i+1];
      end
      q_valid_nxt[OUTSTANDING_DEPTH-1] = 1'b0;
    end
    // New tag goes into the first free slot after the retire.
    if (accept) begin
      for (int i = 0; i < OUTSTANDING_DEPTH; i++) begin
        if (!placed && !q_valid_nxt[i]) begin
          q_valid_nxt[i] = 1'b1;
          q_addr_nxt[i]  = accept_addr[31:2];
          placed         = 1'b1;
        end
      end
    end
  end

  // ----------------------------------------
  // Control registers.
  // ----------------------------------------
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      q_valid   <= '0;
      h_valid   <= '0;
      buf_ready <= 1'b0;
    end else begin
      q_valid   <= q_valid_nxt;
      buf_ready <= 1'b1;
      if (rsp_valid) begin
        h_valid[0] <= q_valid[0];
        for (int i = 1; i < HISTORY_DEPTH; i++) begin
          h_valid[i] <= h_valid[i-1];
        end
      end
    end
  end

  // ----------------------------------------
  // Tag addresses and word data.
  // ----------------------------------------
  always_ff @(posedge clk) begin
    q_addr <= q_addr_nxt;
    // Returning word shifts in with the tag it answers.
    if (rsp_valid) begin
      h_addr[0] <= q_addr[0];
      h_data[0] <= rsp_data;
      for (int i = 1; i < HISTORY_DEPTH; i++) begin
        h_addr[i] <= h_addr[i-1];
        h_data[i] <= h_data[i-1];
      end
    end
  end

  // ----------------------------------------
  // Snapshots.
  // ----------------------------------------
  always_comb begin : snapshot_comb
    for (int i = 0; i < OUTSTANDING_DEPTH; i++) begin
      sent_snapshot[i].valid = q_valid[i];
      sent_snapshot[i].addr  = q_addr[i];
    end
    // Word on the bus this cycle.
    valid_snapshot[0].tag.valid = rsp_valid && q_valid[0];
    valid_snapshot[0].tag.addr  = q_addr[0];
    valid_snapshot[0].data      = rsp_data;
    for (int i = 0; i < HISTORY_DEPTH; i++) begin
      valid_snapshot[i+1].tag.valid = h_valid[i];
      valid_snapshot[i+1].tag.addr  = h_addr[i];
      valid_snapshot[i+1].data      = h_data[i];
    end
  end

  // No room while the last slot is taken or right after reset.
  assign queue_full = q_valid[OUTSTANDING_DEPTH-1] || !buf_ready;

  // Prefetcher honours the full flag.
  accept_not_full: assert property (@(posedge clk) disable iff (!rest)
    accept |-> !queue_full);

  // Memory only answers reads it was given.
  rsp_not_empty: assert property (@(posedge clk) disable iff (!rest)
    rsp_valid |-> q_valid[0]);

endmodule

`default_nettype wire

//--- ifu/ifu_issue.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_issue #(
  parameter ifu_pkg::xlen_t RESET_ADDR = 32'h0000_0000
) (
  input  wire                           clk,
  input  wire                           rest,
  input  wire ifu_pkg::valid_snapshot_t valid_snapshot,
  input  wire ifu_pkg::sent_snapshot_t  sent_snapshot,
  input  wire                           jump_en,
  input  wire ifu_pkg::xlen_t           jump_addr,
  input  wire                           flush_en,
  output ifu_pkg::xlen_t                pc,
  output ifu_pkg::xlen_t                next_pc,
  output ifu_pkg::pc_request_t          pc_request,
  output ifu_pkg::xlen_t                dely_istr,
  output ifu_pkg::xlen_t                dely_pc,
  output logic                          dely_valid
);

  import ifu_pkg::*;

  // Pc holds a real fetch address after the first cycle.
  logic        pc_valid;

  // Word holding pc and the word after it.
  word_addr_t  word_lo;
  word_addr_t  word_hi;
  buf_entry_t  lo_entry;
  buf_entry_t  hi_entry;
  logic        lo_sent;
  logic        hi_sent;

  // Halfwords of the current instruction.
  logic [15:0] half_lo;
  logic [15:0] half_hi;
  logic        hi_ready;
  logic        is_32bit;

  // Recognized instruction.
  logic        istr_valid;
  xlen_t       istr;
  xlen_t       pc_step;

  // ----------------------------------------
  // Halfword lookup.
  // ----------------------------------------
  assign word_lo  = pc[31:2];
  assign word_hi  = pc[31:2] + word_addr_t'(1);

  assign lo_entry = tag_lookup(word_lo, valid_snapshot);
  assign hi_entry = tag_lookup(word_hi, valid_snapshot);
  assign lo_sent  = tag_in_flight(word_lo, sent_snapshot);
  assign hi_sent  = tag_in_flight(word_hi, sent_snapshot);

  // Upper half of a word straddles into the next word.
  assign half_lo  = pc[1] ? lo_entry.data[31:16] : lo_entry.data[15:0];
  assign half_hi  = pc[1] ? hi_entry.data[15:0]  : lo_entry.data[31:16];
  assign hi_ready = pc[1] ? hi_entry.tag.valid   : lo_entry.tag.valid;

  // Low bits 11 mark a full-size instruction.
  assign is_32bit   = (half_lo[1:0] == 2'b11);
  assign istr_valid = pc_valid && lo_entry.tag.valid && (!is_32bit || hi_ready);
  assign istr       = is_32bit ? {half_hi, half_lo} : {16'h0000, half_lo};

  // Missing words that nobody has asked for yet.
  assign pc_request.pc_word   = !lo_entry.tag.valid && !lo_sent;
  assign pc_request.next_word = lo_entry.tag.valid && is_32bit && pc[1] &&
                                !hi_entry.tag.valid && !hi_sent;

  // ----------------------------------------
  // Next pc.
  // ----------------------------------------
  assign pc_step = is_32bit ? 32'd4 : 32'd2;

  always_comb begin : next_pc_comb
    if (jump_en) begin
      next_pc = jump_addr;
    end else if (istr_valid) begin
      next_pc = pc + pc_step;
    end else begin
      next_pc = pc;
    end
  end

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      pc_valid <= 1'b0;
      pc       <= RESET_ADDR;
    end else begin
      pc_valid <= 1'b1;
      pc       <= next_pc;
    end
  end

  // ----------------------------------------
  // Delivery register.
  // ----------------------------------------
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      dely_valid <= 1'b0;
    end else begin
      // Flushed instruction is dropped.
      dely_valid <= istr_valid && !flush_en;
    end
  end

  always_ff @(posedge clk) begin
    dely_istr <= istr;
    dely_pc   <= pc;
  end

  // Jump targets and the reset address keep pc on a halfword.
  pc_halfword: assert property (@(posedge clk) disable iff (!rest)
    pc[0] == 1'b0);

endmodule

`default_nettype wire

//--- ifu/ifu_top.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_top #(
  parameter ifu_pkg::xlen_t RESET_ADDR = 32'h0000_0000
) (
  input  wire                        clk,
  input  wire                        rest,
  output mem_bus_pkg::mem_req_t      mem_req,
  input  wire mem_bus_pkg::mem_rsp_t mem_rsp,
  input  wire                        jump_en,
  input  wire ifu_pkg::xlen_t        jump_addr,
  input  wire                        flush_en,
  output ifu_pkg::xlen_t             dely_istr,
  output ifu_pkg::xlen_t             dely_pc,
  output logic                       dely_valid
);

  import ifu_pkg::*;

  // Pc state from the issue stage.
  xlen_t           pc;
  xlen_t           next_pc;
  pc_request_t     pc_request;

  // Buffer state seen by both prefetcher and issue stage.
  sent_snapshot_t  sent_snapshot;
  valid_snapshot_t valid_snapshot;
  logic            queue_full;

  // Read handshake on the bus.
  logic            accept;

  assign accept = mem_req.read && mem_rsp.request_ready;

  // ----------------------------------------
  // Prefetcher.
  // ----------------------------------------
  ifu_prefetch u_prefetch (
    .pc             (pc),
    .next_pc        (next_pc),
    .pc_request     (pc_request),
    .sent_snapshot  (sent_snapshot),
    .valid_snapshot (valid_snapshot),
    .queue_full     (queue_full),
    .mem_req        (mem_req)
  );

  // ----------------------------------------
  // In-flight queue and word history.
  // ----------------------------------------
  ifu_fetch_buffer u_fetch_buffer (
    .clk            (clk),
    .rest           (rest),
    .accept         (accept),
    .accept_addr    (mem_req.address),
    .rsp_valid      (mem_rsp.read_data_valid),
    .rsp_data       (mem_rsp.read_data),
    .sent_snapshot  (sent_snapshot),
    .valid_snapshot (valid_snapshot),
    .queue_full     (queue_full)
  );

  // ----------------------------------------
  // Instruction assembly and delivery.
  // ----------------------------------------
  ifu_issue #(
    .RESET_ADDR (RESET_ADDR)
  ) u_issue (
    .clk            (clk),
    .rest           (rest),
    .valid_snapshot (valid_snapshot),
    .sent_snapshot  (sent_snapshot),
    .jump_en        (jump_en),
    .jump_addr      (jump_addr),
    .flush_en       (flush_en),
    .pc             (pc),
    .next_pc        (next_pc),
    .pc_request     (pc_request),
    .dely_istr      (dely_istr),
    .dely_pc        (dely_pc),
    .dely_valid     (dely_valid)
  );

endmodule

`default_nettype wire

//--- tb/ifu_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_mem_model (
  input  wire                        clk,
  input  wire                        rest,
  input  wire mem_bus_pkg::mem_req_t mem_req,
  output mem_bus_pkg::mem_rsp_t      mem_rsp,
  output int                         inflight
);

  import ifu_pkg::*;

  // Accepted reads, oldest first, with the edge they may answer on.
  xlen_t addr_q[$];
  int    due_q[$];
  int    edge_cnt;

  // Low bits 11 on every third halfword, upper bits hold the index.
  function automatic logic [15:0] mem_half(xlen_t h);
    logic [1:0] low;
    low = (h % 32'd3 == 32'd0) ? 2'b11 : 2'b01;
    return {h[13:0], low};
  endfunction

  function automatic xlen_t mem_word(xlen_t byte_addr);
    xlen_t h;
    h = byte_addr >> 1;
    return {mem_half(h + 32'd1), mem_half(h)};
  endfunction

  always @(posedge clk or negedge rest) begin
    if (!rest) begin
      addr_q.delete();
      due_q.delete();
      edge_cnt = 0;
      inflight <= 0;
      mem_rsp  <= '0;
    end else begin
      edge_cnt = edge_cnt + 1;
      // Word shown in the last cycle was consumed.
      if (mem_rsp.read_data_valid) begin
        addr_q.delete(0);
        due_q.delete(0);
      end
      // Answer one to three cycles after the accepting edge.
      if (mem_req.read && mem_rsp.request_ready) begin
        addr_q.push_back(mem_req.address);
        due_q.push_back(edge_cnt + int'($urandom % 32'd3));
      end
      inflight <= addr_q.size();
      mem_rsp.request_ready <= ($urandom % 32'd10) < 32'd7;
      // Head of queue only, so answers stay in order.
      if (addr_q.size() > 0 && due_q[0] <= edge_cnt) begin
        mem_rsp.read_data_valid <= 1'b1;
        mem_rsp.read_data       <= mem_word(addr_q[0]);
      end else begin
        mem_rsp.read_data_valid <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- tb/ifu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_tb;

  import ifu_pkg::*;
  import mem_bus_pkg::*;

  localparam xlen_t RESET_ADDR  = 32'h0000_0000;
  localparam int    DELY_TARGET = 200;
  localparam int    JUMP_COUNT  = 4;
  localparam int    WAIT_LIMIT  = 4000;

  logic     clk;
  logic     rest;
  logic     jump_en;
  xlen_t    jump_addr;
  logic     flush_en;
  mem_req_t mem_req;
  mem_rsp_t mem_rsp;
  xlen_t    dely_istr;
  xlen_t    dely_pc;
  logic     dely_valid;
  int       inflight;

  // Reference state for the delivered stream.
  xlen_t exp_pc;
  xlen_t exp_istr;
  logic  exp_is32;
  logic  after_jump;
  xlen_t jump_pc;
  int    dely_count;

  // One-cycle history for reset and bus checks.
  logic  rest_seen = 1'b0;
  int    cycle_cnt = 0;
  logic  prev_wait = 1'b0;
  logic  prev_jump = 1'b0;
  xlen_t prev_addr = '0;

  int err_reset    = 0;
  int err_seq      = 0;
  int err_istr     = 0;
  int err_jump     = 0;
  int err_bus      = 0;
  int err_progress = 0;

  always #5 clk = ~clk;

  ifu_top #(
    .RESET_ADDR (RESET_ADDR)
  ) u_ifu_top (
    .clk        (clk),
    .rest       (rest),
    .mem_req    (mem_req),
    .mem_rsp    (mem_rsp),
    .jump_en    (jump_en),
    .jump_addr  (jump_addr),
    .flush_en   (flush_en),
    .dely_istr  (dely_istr),
    .dely_pc    (dely_pc),
    .dely_valid (dely_valid)
  );

  ifu_mem_model u_mem_model (
    .clk      (clk),
    .rest     (rest),
    .mem_req  (mem_req),
    .mem_rsp  (mem_rsp),
    .inflight (inflight)
  );

  // ----------------------------------------
  // Expected instruction stream.
  // ----------------------------------------
  function automatic logic [15:0] expect_half(xlen_t h);
    logic [1:0] low;
    low = (h % 32'd3 == 32'd0) ? 2'b11 : 2'b01;
    return {h[13:0], low};
  endfunction

  // Full word for 32-bit, zero upper half otherwise.
  function automatic xlen_t expect_istr(xlen_t pc);
    logic [15:0] lo;
    lo = expect_half(pc >> 1);
    if (lo[1:0] == 2'b11) begin
      return {expect_half((pc >> 1) + 32'd1), lo};
    end
    return {16'h0000, lo};
  endfunction

  assign exp_istr = expect_istr(exp_pc);
  assign exp_is32 = (exp_istr[1:0] == 2'b11);

  // Jump wins over the step of a delivery in the same cycle.
  always @(posedge clk or negedge rest) begin
    if (!rest) begin
      exp_pc     <= RESET_ADDR;
      after_jump <= 1'b0;
      jump_pc    <= '0;
    end else if (jump_en) begin
      exp_pc     <= jump_addr;
      after_jump <= 1'b1;
      jump_pc    <= jump_addr;
    end else if (dely_valid) begin
      exp_pc     <= exp_pc + (exp_is32 ? 32'd4 : 32'd2);
      after_jump <= 1'b0;
    end
  end

  always @(posedge clk or negedge rest) begin
    if (!rest) begin
      dely_count <= 0;
    end else if (dely_valid) begin
      dely_count <= dely_count + 1;
    end
  end

  always @(posedge clk) begin
    rest_seen <= rest;
    cycle_cnt <= cycle_cnt + 1;
    prev_wait <= rest && mem_req.read && !mem_rsp.request_ready;
    prev_jump <= jump_en;
    prev_addr <= mem_req.address;
  end

  // ----------------------------------------
  // Checks.
  // ----------------------------------------
  reset_quiet: assert property (@(posedge clk)
    (cycle_cnt > 0 && !rest_seen) |-> (!dely_valid && !mem_req.read))
    else begin
      err_reset++;
      $display("Fail reset_quiet: expected valid/read 0/0, actual %b/%b",
               $sampled(dely_valid), $sampled(mem_req.read));
    end

  seq_pc: assert property (@(posedge clk) disable iff (!rest)
    dely_valid |-> dely_pc == exp_pc)
    else begin
      err_seq++;
      $display("Fail seq_pc: expected %h, actual %h", $sampled(exp_pc), $sampled(dely_pc));
    end

  // Compressed instructions compare the low half only.
  istr_content: assert property (@(posedge clk) disable iff (!rest)
    dely_valid |-> (exp_is32 ? dely_istr : {16'h0000, dely_istr[15:0]}) == exp_istr)
    else begin
      err_istr++;
      $display("Fail istr_content: expected %h, actual %h",
               $sampled(exp_istr), $sampled(dely_istr));
    end

  jump_redirect: assert property (@(posedge clk) disable iff (!rest)
    (after_jump && dely_valid) |-> dely_pc == jump_pc)
    else begin
      err_jump++;
      $display("Fail jump_redirect: expected %h, actual %h",
               $sampled(jump_pc), $sampled(dely_pc));
    end

  bus_align: assert property (@(posedge clk) disable iff (!rest)
    mem_req.read |-> mem_req.address[1:0] == 2'b00)
    else begin
      err_bus++;
      $display("Fail bus_align: expected 0, actual %0d", $sampled(mem_req.address[1:0]));
    end

  bus_inflight: assert property (@(posedge clk) disable iff (!rest)
    inflight <= OUTSTANDING_DEPTH)
    else begin
      err_bus++;
      $display("Fail bus_inflight: expected <= %0d, actual %0d",
               OUTSTANDING_DEPTH, $sampled(inflight));
    end

  // A redirect may move the pending read.
  bus_hold: assert property (@(posedge clk) disable iff (!rest)
    (prev_wait && !prev_jump && !jump_en) |->
      (mem_req.read && mem_req.address == prev_addr))
    else begin
      err_bus++;
      $display("Fail bus_hold: expected %h, actual %h (read %b)",
               $sampled(prev_addr), $sampled(mem_req.address), $sampled(mem_req.read));
    end

  // ----------------------------------------
  // Stimulus.
  // ----------------------------------------
  task automatic wait_deliveries(input int target, output bit ok);
    int waited;
    waited = 0;
    while (dely_count < target && waited < WAIT_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    ok = (dely_count >= target);
    if (!ok) begin
      err_progress++;
      $display("Timeout: only %0d of %0d deliveries after %0d cycles",
               dely_count, target, waited);
    end
  endtask

  // One-cycle redirect with flush.
  task automatic apply_jump(input xlen_t target);
    jump_en   <= 1'b1;
    flush_en  <= 1'b1;
    jump_addr <= target;
    @(posedge clk);
    jump_en   <= 1'b0;
    flush_en  <= 1'b0;
  endtask

  initial begin : main
    bit    ok;
    xlen_t target;
    int    total;
    void'($urandom(70));
    clk       = 1'b0;
    rest      = 1'b0;
    jump_en   = 1'b0;
    jump_addr = '0;
    flush_en  = 1'b0;
    repeat (10) @(posedge clk);
    rest <= 1'b1;
    ok = 1'b1;
    // Each jump lands in a fresh 4 KiB region.
    for (int j = 0; j <= JUMP_COUNT; j++) begin
      if (ok) begin
        wait_deliveries(DELY_TARGET * (j + 1) / (JUMP_COUNT + 1), ok);
        if (ok && j < JUMP_COUNT) begin
          target = 32'h1000 * xlen_t'(j + 1) + (($urandom % 32'h800) & 32'h0000_07fe);
          apply_jump(target);
        end
      end
    end
    repeat (5) @(posedge clk);
    total = err_reset + err_seq + err_istr + err_jump + err_bus + err_progress;
    $write("Errors: reset_quiet=%0d seq_pc=%0d istr_content=%0d jump_redirect=%0d",
           err_reset, err_seq, err_istr, err_jump);
    $display(" bus_rules=%0d progress=%0d total=%0d deliveries=%0d",
             err_bus, err_progress, total, dely_count);
    if (total == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
common/ifu_pkg.sv
common/mem_bus_pkg.sv
ifu/ifu_prefetch.sv
ifu/ifu_fetch_buffer.sv
ifu/ifu_issue.sv
ifu/ifu_top.sv
tb/ifu_mem_model.sv
tb/ifu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the fetch unit testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module ifu_tb \
  -Mdir "$BUILD_DIR" -o ifu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/ifu_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "STATUS: PASS" "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1
